/* tilemap_macros.svh */
`ifndef TILEMAP_MACROS_SVH
`define TILEMAP_MACROS_SVH

// Geometry of one tile row
`define TILE_W 8
`define PLANES 3

// Graphics bus carries four pixels of all three planes per fetch
`define FETCH_W 12

// Field widths of a tagged pixel
`define PRI_W 3
`define COLOR_W 8

// Dot code that lets the layer below show through
`define DOT_TRANSPARENT 3'd7

`endif

/* tilemap_pkg.sv */
`include "tilemap_macros.svh"

package tilemap_pkg;

	// Pixel as it moves along the chain
	// Priority on top, dot code in the low bits
	typedef struct packed {
		logic [`PRI_W-1:0]   pri;
		logic [`COLOR_W-1:0] color;
		logic [`PLANES-1:0]  dot;
	} pixel_t;

	// CPU register map on the 3-bit address
	// Only two addresses are decoded, the rest are ignored
	typedef enum logic [2:0] {
		REG_PRI_A = 3'd1,
		REG_PRI_B = 3'd5
	} cpu_reg_e;

	// Layer identity, also the 2H phase that fetches it
	typedef enum logic {
		LAYER_A = 1'b0,
		LAYER_B = 1'b1
	} layer_e;

endpackage

/* tile_row_if.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

// One assembled tile row for one layer
// All fields are levels that only move on a capture
interface tile_row_if;

	// Bit planes, bit 7 is the leftmost pixel
	logic [`TILE_W-1:0]  plane0;
	logic [`TILE_W-1:0]  plane1;
	logic [`TILE_W-1:0]  plane2;

	// Colour attribute shared by the whole row
	logic [`COLOR_W-1:0] attr;

	// Row latch side
	modport source (output plane0, output plane1, output plane2, output attr);

	// Shifter side
	modport sink (input plane0, input plane1, input plane2, input attr);

endinterface

/* tile_row_latch.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module tile_row_latch import tilemap_pkg::*; (
	input  logic                CLK_6M,
	input  logic                rst,
	input  logic                clk_2h,
	input  logic [`FETCH_W-1:0] gdi,
	input  logic [`COLOR_W-1:0] mdi,
	tile_row_if.source          row_a,
	tile_row_if.source          row_b
);

	// Pixels per plane in one fetch
	localparam int NIB_W  = `FETCH_W / `PLANES;
	localparam int LAYERS = 2;

	// Row storage per layer, first index is a layer_e value
	logic [`TILE_W-1:0]  plane_q [LAYERS][`PLANES];
	logic [`COLOR_W-1:0] attr_q  [LAYERS];

	// Previous 2H level
	logic                clk_2h_q;
	logic                phase_edge;
	layer_e              cap_layer;

	////////////////////////////////////////////////////////////////////////////
	// 2H phase tracking
	////////////////////////////////////////////////////////////////////////////

	// Any change of 2H marks a finished fetch on the shared bus
	assign phase_edge = (clk_2h != clk_2h_q);
	// New 2H level names the layer whose data is on the bus
	assign cap_layer  = layer_e'(clk_2h);

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			clk_2h_q <= 1'b0;
			for (int l = 0; l < LAYERS; l++) begin
				attr_q[l] <= '0;
				for (int p = 0; p < `PLANES; p++) begin
					plane_q[l][p] <= '0;
				end
			end
		end else begin
			clk_2h_q <= clk_2h;
			if (phase_edge) begin
				attr_q[cap_layer] <= mdi;
				// Old upper half drops to the lower half
				// New fetch fills the upper half
				for (int p = 0; p < `PLANES; p++) begin
					plane_q[cap_layer][p] <= {gdi[p*NIB_W +: NIB_W],
						plane_q[cap_layer][p][`TILE_W-1 -: NIB_W]};
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Row outputs
	////////////////////////////////////////////////////////////////////////////

	assign row_a.plane0 = plane_q[LAYER_A][0];
	assign row_a.plane1 = plane_q[LAYER_A][1];
	assign row_a.plane2 = plane_q[LAYER_A][2];
	assign row_a.attr   = attr_q[LAYER_A];

	assign row_b.plane0 = plane_q[LAYER_B][0];
	assign row_b.plane1 = plane_q[LAYER_B][1];
	assign row_b.plane2 = plane_q[LAYER_B][2];
	assign row_b.attr   = attr_q[LAYER_B];

	// Each fetch holds the bus for two pixels, so 2H never moves twice in a row
	assert property (@(posedge CLK_6M) disable iff (rst)
		phase_edge |=> !phase_edge)
		else $error("clk_2h changed on two consecutive clocks");

endmodule

/* layer_shifter.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module layer_shifter import tilemap_pkg::*; #(
	parameter layer_e LAYER = LAYER_A
) (
	input  logic              CLK_6M,
	input  logic              rst,
	tile_row_if.sink          row,
	input  logic              load,
	input  logic              flip,
	input  logic [`PRI_W-1:0] pri,
	output pixel_t            pixel
);

	localparam int CNT_W = $clog2(`TILE_W);
	localparam logic [CNT_W-1:0] RUN_MAX = CNT_W'(`TILE_W - 1);

	// Row planes as an array so all planes share one loop
	logic [`TILE_W-1:0]  row_planes [`PLANES];
	// Plane shift registers and the attribute of the row in flight
	logic [`TILE_W-1:0]  plane_sr [`PLANES];
	logic [`COLOR_W-1:0] attr_q;
	// Clocks since the last load, stops at the last pixel
	logic [CNT_W-1:0]    run_cnt;
	logic [`PLANES-1:0]  dot;

	assign row_planes[0] = row.plane0;
	assign row_planes[1] = row.plane1;
	assign row_planes[2] = row.plane2;

	////////////////////////////////////////////////////////////////////////////
	// Load and shift
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			attr_q  <= '0;
			run_cnt <= RUN_MAX;
			for (int p = 0; p < `PLANES; p++) begin
				plane_sr[p] <= '0;
			end
		end else if (load) begin
			attr_q  <= row.attr;
			run_cnt <= '0;
			for (int p = 0; p < `PLANES; p++) begin
				plane_sr[p] <= row_planes[p];
			end
		end else begin
			if (run_cnt != RUN_MAX)
				run_cnt <= run_cnt + 1'b1;
			// Flipped rows walk from bit 0 upward
			for (int p = 0; p < `PLANES; p++) begin
				plane_sr[p] <= flip ? (plane_sr[p] >> 1) : (plane_sr[p] << 1);
			end
		end
	end

	// Edge bit of each plane, on the side the row leaves from
	always_comb begin
		for (int p = 0; p < `PLANES; p++) begin
			dot[p] = flip ? plane_sr[p][0] : plane_sr[p][`TILE_W-1];
		end
	end

	// Priority follows the register live, colour sticks to the row
	assign pixel = {pri, attr_q, dot};

	// A new row may only come in after the last pixel of the old one left
	assert property (@(posedge CLK_6M) disable iff (rst)
		load |-> (run_cnt == RUN_MAX))
		else $error("layer %0d loaded before its row finished", LAYER);

endmodule

/* priority_regs.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module priority_regs import tilemap_pkg::*; (
	input  logic                CLK_6M,
	input  logic                rst,
	input  logic                latch,
	input  logic [2:0]          ca,
	input  logic [`COLOR_W-1:0] mdi,
	output logic [`PRI_W-1:0]   pri_a,
	output logic [`PRI_W-1:0]   pri_b
);

	// Register address seen through the CPU map
	cpu_reg_e reg_sel;

	assign reg_sel = cpu_reg_e'(ca);

	////////////////////////////////////////////////////////////////////////////
	// CPU write port
	////////////////////////////////////////////////////////////////////////////

	// Priority sits in data bits 3..1, bit 0 is not used
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pri_a <= '0;
			pri_b <= '0;
		end else if (latch) begin
			case (reg_sel)
				REG_PRI_A: pri_a <= mdi[`PRI_W:1];
				REG_PRI_B: pri_b <= mdi[`PRI_W:1];
				// Other addresses belong to other registers
				default: begin
				end
			endcase
		end
	end

	// Write data on the shared bus must be settled during a strobe
	assert property (@(posedge CLK_6M) disable iff (rst)
		latch |-> !$isunknown(mdi))
		else $error("mdi has unknown bits during a latch strobe");

endmodule

/* layer_mixer.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module layer_mixer import tilemap_pkg::*; (
	input  logic   CLK_6M,
	input  logic   rst,
	input  pixel_t pix_a,
	input  pixel_t pix_b,
	input  pixel_t pix_in,
	output pixel_t pix_out
);

	// Stage one result between the two layers
	logic   b_wins;
	pixel_t pix_layer;

	// Stage two result against the chain
	logic   layer_wins;
	pixel_t pix_mux;

	////////////////////////////////////////////////////////////////////////////
	// Layer A against layer B
	////////////////////////////////////////////////////////////////////////////

	// Ties go to layer A
	assign b_wins    = (pix_b.dot != `DOT_TRANSPARENT) && (pix_b.pri > pix_a.pri);
	assign pix_layer = b_wins ? pix_b : pix_a;

	////////////////////////////////////////////////////////////////////////////
	// Tile layers against the incoming chain
	////////////////////////////////////////////////////////////////////////////

	// Ties go to the earlier chip in the chain
	assign layer_wins = (pix_layer.dot != `DOT_TRANSPARENT) &&
		(pix_layer.pri > pix_in.pri);
	assign pix_mux    = layer_wins ? pix_layer : pix_in;

	// One register stage towards the next chip
	always_ff @(posedge CLK_6M) begin
		if (rst)
			pix_out <= '0;
		else
			pix_out <= pix_mux;
	end

	// An output that differs from the chain pixel came from a layer that beat it
	assert property (@(posedge CLK_6M) disable iff (rst)
		!$past(rst) && (pix_out != $past(pix_in)) |->
			(pix_out.dot != `DOT_TRANSPARENT) && (pix_out.pri > $past(pix_in.pri)))
		else $error("layer pixel output without beating the chain input");

endmodule

/* tilemap_gen.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module tilemap_gen import tilemap_pkg::*; (
	input  logic                CLK_6M,
	input  logic                rst,
	// Graphics and attribute buses, time-shared by 2H
	input  logic [`FETCH_W-1:0] gdi,
	input  logic [`COLOR_W-1:0] mdi,
	// Horizontal timing
	input  logic                clk_2h,
	input  logic                ha2,
	input  logic                hb2,
	input  logic                flip,
	// CPU register write
	input  logic                latch,
	input  logic [2:0]          ca,
	// Pixel chain from the previous chip
	input  logic [`PRI_W-1:0]   pri_in,
	input  logic [`COLOR_W-1:0] color_in,
	input  logic [`PLANES-1:0]  dot_in,
	// Pixel chain to the next chip
	output logic [`PRI_W-1:0]   pri_out,
	output logic [`COLOR_W-1:0] color_out,
	output logic [`PLANES-1:0]  dot_out
);

	pixel_t            pix_in;
	pixel_t            pix_a;
	pixel_t            pix_b;
	pixel_t            pix_out;
	logic [`PRI_W-1:0] pri_a;
	logic [`PRI_W-1:0] pri_b;

	// Assembled rows, one per layer
	tile_row_if row_a ();
	tile_row_if row_b ();

	assign pix_in = {pri_in, color_in, dot_in};

	////////////////////////////////////////////////////////////////////////////
	// Fetch, priority and per-layer pixel streams
	////////////////////////////////////////////////////////////////////////////

	tile_row_latch tile_row_latch_inst (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.clk_2h (clk_2h),
		.gdi    (gdi),
		.mdi    (mdi),
		.row_a  (row_a.source),
		.row_b  (row_b.source)
	);

	priority_regs priority_regs_inst (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.latch  (latch),
		.ca     (ca),
		.mdi    (mdi),
		.pri_a  (pri_a),
		.pri_b  (pri_b)
	);

	layer_shifter #(.LAYER(LAYER_A)) layer_shifter_a (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.row    (row_a.sink),
		.load   (ha2),
		.flip   (flip),
		.pri    (pri_a),
		.pixel  (pix_a)
	);

	layer_shifter #(.LAYER(LAYER_B)) layer_shifter_b (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.row    (row_b.sink),
		.load   (hb2),
		.flip   (flip),
		.pri    (pri_b),
		.pixel  (pix_b)
	);

	// Merge the layers and the chain
	layer_mixer layer_mixer_inst (
		.CLK_6M  (CLK_6M),
		.rst     (rst),
		.pix_a   (pix_a),
		.pix_b   (pix_b),
		.pix_in  (pix_in),
		.pix_out (pix_out)
	);

	assign pri_out   = pix_out.pri;
	assign color_out = pix_out.color;
	assign dot_out   = pix_out.dot;

endmodule

/* tb_tilemap_gen.sv */
`timescale 1ns/1ps
`include "tilemap_macros.svh"

module tb_tilemap_gen import tilemap_pkg::*; ();

	// Tiles per test, test 5 replays the stream of test 4
	localparam int TILES_A   = 24;
	localparam int TILES_PRI = 40;
	localparam int TILES_MIX = 40;
	localparam int GAP       = 12;
	// All tiles, the gaps, reset and setup, plus slack
	localparam int CYC_LIMIT = 8 * (TILES_A + TILES_PRI + 2 * TILES_MIX) + 6 * GAP + 64;
	localparam int MAX_CYC   = CYC_LIMIT + 16;

	logic                CLK_6M;
	logic                rst;
	logic [`FETCH_W-1:0] gdi;
	logic [`COLOR_W-1:0] mdi;
	logic                clk_2h, ha2, hb2, flip, latch;
	logic [2:0]          ca;
	logic [`PRI_W-1:0]   pri_in, pri_out;
	logic [`COLOR_W-1:0] color_in, color_out;
	logic [`PLANES-1:0]  dot_in, dot_out;

	// Stimulus and model state
	logic [31:0]       seed;
	logic [31:0]       replay;
	int                ed;
	int                cycle;
	int                zero_until = 10;
	int                checks;
	int                errors;
	int                empty_tests;
	int                chk_mark;
	int                err_mark;
	bit                flp_m;
	logic [`PRI_W-1:0] pri_m [2];

	// Expected inputs of the mixer, indexed by the edge that samples them
	pixel_t            lay      [2][MAX_CYC];
	bit                lay_ok   [2][MAX_CYC];
	logic [`PRI_W-1:0] pri_at   [2][MAX_CYC];
	pixel_t            chain_at [MAX_CYC];

	tilemap_gen tilemap_gen_inst (.*);

	always #5 CLK_6M = ~CLK_6M;

	// Edge count and run limit
	always @(posedge CLK_6M) begin
		cycle <= cycle + 1;
		if (cycle == CYC_LIMIT) begin
			$display("Simulation timed out after %0d clock cycles", cycle);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// 32-bit LCG step, the upper half is returned
	function automatic logic [15:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Second fetch lands in the upper nibble of each plane
	function automatic logic [2:0] ref_dot(input logic [11:0] f0, input logic [11:0] f1,
		input int i, input bit flp);
		logic [7:0] row;
		logic [2:0] d;
		for (int p = 0; p < 3; p++) begin
			row  = {f1[p*4 +: 4], f0[p*4 +: 4]};
			d[p] = flp ? row[i] : row[7 - i];
		end
		return d;
	endfunction

	// B needs a strictly higher priority, then the layer must beat the chain
	function automatic pixel_t ref_mix(input pixel_t a, input pixel_t b, input pixel_t c);
		pixel_t l;
		l = (b.dot != `DOT_TRANSPARENT && b.pri > a.pri) ? b : a;
		return (l.dot != `DOT_TRANSPARENT && l.pri > c.pri) ? l : c;
	endfunction

	task automatic check(input pixel_t got, input pixel_t want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %0d ns: %s is pri %0d color %h dot %0d, expected pri %0d color %h dot %0d",
				$time, what, got.pri, got.color, got.dot, want.pri, want.color, want.dot);
		end
	endtask

	// Outputs settle after the rising edge, so look at the falling one
	always @(negedge CLK_6M) begin : compare
		pixel_t a;
		pixel_t b;
		if (cycle >= 1 && cycle <= zero_until) begin
			check({pri_out, color_out, dot_out}, '0, "output after reset");
		end else if (cycle < MAX_CYC && lay_ok[0][cycle] && lay_ok[1][cycle]) begin
			a     = lay[0][cycle];
			a.pri = pri_at[0][cycle];
			b     = lay[1][cycle];
			b.pri = pri_at[1][cycle];
			check({pri_out, color_out, dot_out}, ref_mix(a, b, chain_at[cycle]), "pixel out");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// One clock of inputs, sampled at edge ed
	task automatic drive(input logic h2, input logic [`FETCH_W-1:0] g,
		input logic [`COLOR_W-1:0] m, input logic la, input logic lb, input logic lt,
		input logic [2:0] a, input pixel_t ch);
		clk_2h <= h2;
		gdi    <= g;
		mdi    <= m;
		ha2    <= la;
		hb2    <= lb;
		latch  <= lt;
		ca     <= a;
		{pri_in, color_in, dot_in} <= ch;
		chain_at[ed]  = ch;
		pri_at[0][ed] = pri_m[0];
		pri_at[1][ed] = pri_m[1];
		// Written priority is seen by the mixer one edge later
		if (lt && a == REG_PRI_A)
			pri_m[0] = m[3:1];
		if (lt && a == REG_PRI_B)
			pri_m[1] = m[3:1];
		@(posedge CLK_6M);
		ed++;
	endtask

	// 2H parked high, nothing loaded, chain at zero
	task automatic idle();
		drive(1'b1, '0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	// Load at edge ed puts pixel i in front of the mixer at ed+1+i
	task automatic record_row(input bit l, input logic [11:0] f0, input logic [11:0] f1,
		input logic [7:0] at);
		for (int i = 0; i < `TILE_W; i++) begin
			lay[l][ed + 1 + i]    = {3'd0, at, ref_dot(f0, f1, i, flp_m)};
			lay_ok[l][ed + 1 + i] = 1'b1;
		end
	endtask

	// 8 clocks: fetches A, B, A, B on 2H edges, then load A, then load B
	task automatic play_tile(input bit clear_b, input bit chain_on, input bit cpu_on);
		logic [`FETCH_W-1:0] fe [2][2];
		logic [`COLOR_W-1:0] at [2][2];
		logic [15:0]         r;
		logic [15:0]         r2;
		logic [2:0]          a;
		logic                lt;
		pixel_t              ch;
		for (int l = 0; l < 2; l++) begin
			for (int k = 0; k < 2; k++) begin
				r        = lcg_next();
				fe[l][k] = (clear_b && l == 1) ? 12'hfff : r[11:0];
				r        = lcg_next();
				at[l][k] = r[7:0];
			end
		end
		for (int c = 0; c < `TILE_W; c++) begin
			r  = lcg_next();
			r2 = lcg_next();
			ch = chain_on ? r2[13:0] : '0;
			lt = cpu_on && (c == 1 || c == 5);
			// Mostly the two real registers, sometimes any address
			a  = (r[9:8] == 2'd0) ? REG_PRI_A : (r[9:8] == 2'd1) ? REG_PRI_B : r[12:10];
			if (c == 5)
				record_row(1'b0, fe[0][0], fe[0][1], at[0][1]);
			if (c == 7)
				record_row(1'b1, fe[1][0], fe[1][1], at[1][1]);
			drive(c[1], fe[c[1]][c[2]], lt ? r[7:0] : at[c[1]][c[2]], c == 5, c == 7, lt, a,
				ch);
		end
	endtask

	// Drain the pipeline, then report this test
	task automatic end_test(input int num, input string name);
		repeat (GAP) idle();
		if (checks == chk_mark) begin
			empty_tests++;
			$display("Test %0d (%s) compared no pixels", num, name);
		end
		$display("Test %0d %s: %0d checks, %0d errors", num, name, checks - chk_mark,
			errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	initial begin
		CLK_6M = 1'b0;
		rst      <= 1'b1;
		gdi      <= '0;
		mdi      <= '0;
		clk_2h   <= 1'b1;
		ha2      <= 1'b0;
		hb2      <= 1'b0;
		flip     <= 1'b0;
		latch    <= 1'b0;
		ca       <= '0;
		pri_in   <= '0;
		color_in <= '0;
		dot_in   <= '0;
		seed     = 32'h7e5d_9a7f;
		ed       = 1;
		flp_m    = 1'b0;
		pri_m[0] = '0;
		pri_m[1] = '0;

		repeat (4) idle();
		rst <= 1'b0;
		repeat (6) idle();
		end_test(1, "reset");

		// A at top priority over an empty B
		drive(1'b1, '0, {4'd0, 3'd7, 1'b0}, 1'b0, 1'b0, 1'b1, REG_PRI_A, '0);
		repeat (TILES_A) play_tile(1'b1, 1'b0, 1'b0);
		end_test(2, "layer A alone");

		repeat (TILES_PRI) play_tile(1'b0, 1'b0, 1'b1);
		end_test(3, "layer priority");

		replay = seed;
		repeat (TILES_MIX) play_tile(1'b0, 1'b1, 1'b1);
		end_test(4, "chain pass-through");

		// Same stream again, mirrored
		seed  = replay;
		flip  <= 1'b1;
		flp_m = 1'b1;
		repeat (TILES_MIX) play_tile(1'b0, 1'b1, 1'b1);
		end_test(5, "flip");

		$display("Checks %0d, errors %0d, empty tests %0d", checks, errors, empty_tests);
		if (errors == 0 && empty_tests == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
tilemap_pkg.sv
tile_row_if.sv
tile_row_latch.sv
layer_shifter.sv
priority_regs.sv
layer_mixer.sv
tilemap_gen.sv
tb_tilemap_gen.sv

/* Makefile */
# Verilator flow for the tilemap pixel generator

TOP = tb_tilemap_gen
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --assert -f project.f --top-module $(TOP) -o V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
